/* green_pkg.sv */
// ====================
// Shared widths and packed payload structs for the host channel
// multiplexer and the local memory bridge
// ====================

package green_pkg;

   // ====================
   // Host channel widths
   // ====================
   localparam int HOST_ADDR_W = 32;
   localparam int HOST_DATA_W = 64;
   localparam int HOST_TAG_W  = 8;
   localparam int PORT_ID_W   = 2;

   // Port number sits above the accelerator tag on the FIU side
   localparam int FIU_TAG_W   = HOST_TAG_W + PORT_ID_W;

   // ====================
   // Local memory widths
   // ====================
   localparam int MEM_ADDR_W  = 27;
   localparam int MEM_DATA_W  = 64;
   localparam int MEM_BE_W    = 8;
   localparam int MEM_BURST_W = 7;

   // Accelerator port request
   typedef struct packed {
      logic                   valid;
      logic                   is_write;
      logic [HOST_ADDR_W-1:0] addr;
      logic [HOST_DATA_W-1:0] data;
      logic [HOST_TAG_W-1:0]  tag;
   } host_req_t;

   // Accelerator port response
   typedef struct packed {
      logic                   valid;
      logic                   is_write;
      logic [HOST_DATA_W-1:0] data;
      logic [HOST_TAG_W-1:0]  tag;
   } host_rsp_t;

   // FIU request, tag carries the port number
   typedef struct packed {
      logic                   valid;
      logic                   is_write;
      logic [HOST_ADDR_W-1:0] addr;
      logic [HOST_DATA_W-1:0] data;
      logic [FIU_TAG_W-1:0]   tag;
   } fiu_req_t;

   // FIU response with extended tag
   typedef struct packed {
      logic                   valid;
      logic                   is_write;
      logic [HOST_DATA_W-1:0] data;
      logic [FIU_TAG_W-1:0]   tag;
   } fiu_rsp_t;

   // Avalon-MM style memory command
   typedef struct packed {
      logic                   read;
      logic                   write;
      logic [MEM_ADDR_W-1:0]  address;
      logic [MEM_DATA_W-1:0]  writedata;
      logic [MEM_BE_W-1:0]    byteenable;
      logic [MEM_BURST_W-1:0] burstcount;
   } mem_req_t;

   // Memory read return
   typedef struct packed {
      logic                   readdatavalid;
      logic [MEM_DATA_W-1:0]  readdata;
   } mem_rsp_t;

endpackage

/* port_fifo.sv */
// ====================
// Synchronous show-ahead FIFO with a type parameter
// Shared by host request and memory command buffering
// ====================

`timescale 1ns/10ps

module port_fifo
#(
   parameter type T     = logic,
   parameter int  DEPTH = 8
)
(
   input  logic                         Clk_100,
   input  logic                         rst,
   input  logic                         wr_en,
   input  T                             wr_data,
   input  logic                         rd_en,
   output T                             rd_data,
   output logic                         empty,
   output logic [$clog2(DEPTH+1)-1:0]   count
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   T                 mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic             do_wr;
   logic             do_rd;

   // A full FIFO still takes a write when the head leaves in the same cycle
   assign do_rd = rd_en && !empty;
   assign do_wr = wr_en && ((count < CNT_W'(DEPTH)) || do_rd);

   assign empty   = (count == '0);
   assign rd_data = mem[rd_ptr];

   always_ff @(posedge Clk_100)
   begin
      if (do_wr)
      begin
         mem[wr_ptr] <= wr_data;
      end
   end

   // Pointers wrap at DEPTH, so any depth works
   always_ff @(posedge Clk_100)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_wr)
         begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_rd)
         begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         if (do_wr && !do_rd)
         begin
            count <= count + 1'b1;
         end
         else if (do_rd && !do_wr)
         begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

/* rr_arbiter.sv */
// ====================
// Round-robin arbiter with a rotating priority pointer
// ====================

`timescale 1ns/10ps

module rr_arbiter
#(
   parameter int NUM_PORTS = 3
)
(
   input  logic                 Clk_100,
   input  logic                 rst,
   input  logic [NUM_PORTS-1:0] req,
   input  logic                 advance,
   output logic [NUM_PORTS-1:0] grant
);

   localparam int PTR_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

   logic [PTR_W-1:0] ptr;
   logic [PTR_W-1:0] grant_idx;

   // First requester at or after the pointer, wrapping around
   always_comb
   begin
      int   idx;
      logic found;
      grant     = '0;
      grant_idx = ptr;
      found     = 1'b0;
      for (int i = 0; i < NUM_PORTS; i++)
      begin
         idx = int'(ptr) + i;
         if (idx >= NUM_PORTS)
         begin
            idx = idx - NUM_PORTS;
         end
         if (!found && req[idx])
         begin
            grant[idx] = 1'b1;
            grant_idx  = PTR_W'(idx);
            found      = 1'b1;
         end
      end
   end

   // Winner drops to lowest priority
   always_ff @(posedge Clk_100)
   begin
      if (rst)
      begin
         ptr <= '0;
      end
      else if (advance && (|req))
      begin
         ptr <= (grant_idx == PTR_W'(NUM_PORTS - 1)) ? '0 : grant_idx + 1'b1;
      end
   end

endmodule

/* host_port_mux.sv */
// ====================
// Host channel multiplexer
// Per-port request FIFOs, round-robin issue with port tagging,
// response steering by tag, registered FIU boundary
// ====================

`timescale 1ns/10ps

module host_port_mux
#(
   parameter int NUM_PORTS       = 3,
   parameter int PORT_FIFO_DEPTH = 8
)
(
   input  logic                 Clk_100,
   input  logic                 rst,
   input  green_pkg::host_req_t afu_req [NUM_PORTS],
   output logic [NUM_PORTS-1:0] afu_almfull,
   output green_pkg::host_rsp_t afu_rsp [NUM_PORTS],
   output green_pkg::fiu_req_t  fiu_req,
   input  logic                 fiu_almfull,
   input  green_pkg::fiu_rsp_t  fiu_rsp
);

   localparam int CNT_W = $clog2(PORT_FIFO_DEPTH + 1);

   green_pkg::host_req_t           head [NUM_PORTS];
   logic [CNT_W-1:0]               fifo_count [NUM_PORTS];
   logic [NUM_PORTS-1:0]           fifo_empty;
   logic [NUM_PORTS-1:0]           grant;
   logic [NUM_PORTS-1:0]           pop;
   logic                           issue;
   logic [green_pkg::PORT_ID_W-1:0] sel_idx;
   green_pkg::host_req_t           head_sel;
   green_pkg::fiu_req_t            fiu_nxt;
   logic                           fiu_valid_q;
   green_pkg::fiu_req_t            fiu_data_q;
   logic                           rsp_valid_q;
   green_pkg::fiu_rsp_t            rsp_q;
   logic [green_pkg::PORT_ID_W-1:0] rsp_port;

   // ====================
   // Request buffering
   // ====================
   for (genvar p = 0; p < NUM_PORTS; p++)
   begin : g_port
      port_fifo
      #(
         .T     (green_pkg::host_req_t),
         .DEPTH (PORT_FIFO_DEPTH)
      )
      u_req_fifo
      (
         .Clk_100 (Clk_100),
         .rst     (rst),
         .wr_en   (afu_req[p].valid),
         .wr_data (afu_req[p]),
         .rd_en   (pop[p]),
         .rd_data (head[p]),
         .empty   (fifo_empty[p]),
         .count   (fifo_count[p])
      );

      // Two spare slots cover requests already on their way in
      assign afu_almfull[p] = (fifo_count[p] >= CNT_W'(PORT_FIFO_DEPTH - 2));
      assign pop[p]         = grant[p] && issue;
   end

   // ====================
   // Arbitration and issue
   // ====================
   // Nothing leaves while the FIU signals almost full
   assign issue = !fiu_almfull && !(&fifo_empty);

   rr_arbiter
   #(
      .NUM_PORTS (NUM_PORTS)
   )
   u_arb
   (
      .Clk_100 (Clk_100),
      .rst     (rst),
      .req     (~fifo_empty),
      .advance (issue),
      .grant   (grant)
   );

   always_comb
   begin
      sel_idx = '0;
      for (int i = 0; i < NUM_PORTS; i++)
      begin
         if (grant[i])
         begin
            sel_idx = green_pkg::PORT_ID_W'(i);
         end
      end
   end

   // Port number goes into the upper tag bits
   always_comb
   begin
      head_sel         = head[sel_idx];
      fiu_nxt.valid    = 1'b1;
      fiu_nxt.is_write = head_sel.is_write;
      fiu_nxt.addr     = head_sel.addr;
      fiu_nxt.data     = head_sel.data;
      fiu_nxt.tag      = {sel_idx, head_sel.tag};
   end

   always_ff @(posedge Clk_100)
   begin
      if (rst)
      begin
         fiu_valid_q <= 1'b0;
      end
      else
      begin
         fiu_valid_q <= issue;
      end
   end

   always_ff @(posedge Clk_100)
   begin
      if (issue)
      begin
         fiu_data_q <= fiu_nxt;
      end
   end

   always_comb
   begin
      fiu_req       = fiu_data_q;
      fiu_req.valid = fiu_valid_q;
   end

   // ====================
   // Response steering
   // ====================
   always_ff @(posedge Clk_100)
   begin
      if (rst)
      begin
         rsp_valid_q <= 1'b0;
      end
      else
      begin
         rsp_valid_q <= fiu_rsp.valid;
      end
   end

   always_ff @(posedge Clk_100)
   begin
      if (fiu_rsp.valid)
      begin
         rsp_q <= fiu_rsp;
      end
   end

   assign rsp_port = rsp_q.tag[green_pkg::HOST_TAG_W +: green_pkg::PORT_ID_W];

   // Only the slot named by the tag sees valid; port field is stripped
   always_comb
   begin
      for (int p = 0; p < NUM_PORTS; p++)
      begin
         afu_rsp[p].valid    = rsp_valid_q && (rsp_port == green_pkg::PORT_ID_W'(p));
         afu_rsp[p].is_write = rsp_q.is_write;
         afu_rsp[p].data     = rsp_q.data;
         afu_rsp[p].tag      = rsp_q.tag[green_pkg::HOST_TAG_W-1:0];
      end
   end

endmodule

/* local_mem_bridge.sv */
// ====================
// Local memory pipeline bridge
// Command FIFO under waitrequest, fixed-depth read data pipe
// ====================

`timescale 1ns/10ps

module local_mem_bridge
#(
   parameter int PORT_FIFO_DEPTH     = 8,
   parameter int READDATA_PIPE_DEPTH = 2
)
(
   input  logic                Clk_100,
   input  logic                rst,
   input  green_pkg::mem_req_t s0_req,
   output logic                s0_waitrequest,
   output green_pkg::mem_rsp_t s0_rsp,
   output green_pkg::mem_req_t m0_req,
   input  logic                m0_waitrequest,
   input  green_pkg::mem_rsp_t m0_rsp
);

   localparam int CNT_W = $clog2(PORT_FIFO_DEPTH + 1);

   green_pkg::mem_req_t              cmd_head;
   logic                             cmd_empty;
   logic [CNT_W-1:0]                 cmd_count;
   logic                             accept;
   logic                             pop;
   logic [READDATA_PIPE_DEPTH-1:0]   rdv_pipe;
   logic [green_pkg::MEM_DATA_W-1:0] rdata_pipe [READDATA_PIPE_DEPTH];

   // ====================
   // Command path
   // ====================
   assign accept = (s0_req.read || s0_req.write) && !s0_waitrequest;
   assign pop    = !cmd_empty && !m0_waitrequest;

   // One slot of slack before the FIFO is full
   assign s0_waitrequest = (cmd_count >= CNT_W'(PORT_FIFO_DEPTH - 1));

   port_fifo
   #(
      .T     (green_pkg::mem_req_t),
      .DEPTH (PORT_FIFO_DEPTH)
   )
   u_cmd_fifo
   (
      .Clk_100 (Clk_100),
      .rst     (rst),
      .wr_en   (accept),
      .wr_data (s0_req),
      .rd_en   (pop),
      .rd_data (cmd_head),
      .empty   (cmd_empty),
      .count   (cmd_count)
   );

   // Head is held until the bank drops waitrequest
   always_comb
   begin
      m0_req       = cmd_head;
      m0_req.read  = cmd_head.read && !cmd_empty;
      m0_req.write = cmd_head.write && !cmd_empty;
   end

   // ====================
   // Read data pipe
   // ====================
   always_ff @(posedge Clk_100)
   begin
      if (rst)
      begin
         rdv_pipe <= '0;
      end
      else
      begin
         rdv_pipe[0] <= m0_rsp.readdatavalid;
         for (int i = 1; i < READDATA_PIPE_DEPTH; i++)
         begin
            rdv_pipe[i] <= rdv_pipe[i-1];
         end
      end
   end

   always_ff @(posedge Clk_100)
   begin
      rdata_pipe[0] <= m0_rsp.readdata;
      for (int i = 1; i < READDATA_PIPE_DEPTH; i++)
      begin
         rdata_pipe[i] <= rdata_pipe[i-1];
      end
   end

   assign s0_rsp.readdatavalid = rdv_pipe[READDATA_PIPE_DEPTH-1];
   assign s0_rsp.readdata      = rdata_pipe[READDATA_PIPE_DEPTH-1];

endmodule

/* green_top.sv */
// ====================
// Top level joining the host channel multiplexer
// and the local memory bridge
// ====================

`timescale 1ns/10ps

module green_top
#(
   parameter int NUM_PORTS           = 3,
   parameter int PORT_FIFO_DEPTH     = 8,
   parameter int READDATA_PIPE_DEPTH = 2
)
(
   input  logic                 Clk_100,
   input  logic                 rst,

   // Accelerator host ports
   input  green_pkg::host_req_t afu_req [NUM_PORTS],
   output logic [NUM_PORTS-1:0] afu_almfull,
   output green_pkg::host_rsp_t afu_rsp [NUM_PORTS],

   // FIU host channel
   output green_pkg::fiu_req_t  fiu_req,
   input  logic                 fiu_almfull,
   input  green_pkg::fiu_rsp_t  fiu_rsp,

   // Accelerator side of local memory
   input  green_pkg::mem_req_t  s0_req,
   output logic                 s0_waitrequest,
   output green_pkg::mem_rsp_t  s0_rsp,

   // Memory bank side
   output green_pkg::mem_req_t  m0_req,
   input  logic                 m0_waitrequest,
   input  green_pkg::mem_rsp_t  m0_rsp
);

   // ====================
   // Host channel
   // ====================
   host_port_mux
   #(
      .NUM_PORTS       (NUM_PORTS),
      .PORT_FIFO_DEPTH (PORT_FIFO_DEPTH)
   )
   u_host_mux
   (
      .Clk_100     (Clk_100),
      .rst         (rst),
      .afu_req     (afu_req),
      .afu_almfull (afu_almfull),
      .afu_rsp     (afu_rsp),
      .fiu_req     (fiu_req),
      .fiu_almfull (fiu_almfull),
      .fiu_rsp     (fiu_rsp)
   );

   // ====================
   // Local memory
   // ====================
   // Independent of the host path
   local_mem_bridge
   #(
      .PORT_FIFO_DEPTH     (PORT_FIFO_DEPTH),
      .READDATA_PIPE_DEPTH (READDATA_PIPE_DEPTH)
   )
   u_mem_bridge
   (
      .Clk_100        (Clk_100),
      .rst            (rst),
      .s0_req         (s0_req),
      .s0_waitrequest (s0_waitrequest),
      .s0_rsp         (s0_rsp),
      .m0_req         (m0_req),
      .m0_waitrequest (m0_waitrequest),
      .m0_rsp         (m0_rsp)
   );

endmodule

/* green_props.sv */
// ====================
// Concurrent assertions on the host channel multiplexer
// ====================

`timescale 1ns/10ps

module green_props
#(
   parameter int NUM_PORTS = 3
)
(
   input logic                 Clk_100,
   input logic                 rst,
   input logic                 fiu_almfull,
   input green_pkg::fiu_req_t  fiu_req,
   input green_pkg::host_rsp_t afu_rsp [NUM_PORTS],
   input logic [NUM_PORTS-1:0] afu_almfull
);

   logic [NUM_PORTS-1:0] rsp_valid;

   always_comb
   begin
      for (int p = 0; p < NUM_PORTS; p++)
      begin
         rsp_valid[p] = afu_rsp[p].valid;
      end
   end

   // No issue right after an almost-full cycle
   a_almfull_stall: assert property (@(posedge Clk_100) disable iff (rst)
      fiu_almfull |=> !fiu_req.valid)
      else $error("fiu_req valid after fiu_almfull");

   a_one_rsp: assert property (@(posedge Clk_100) disable iff (rst) $onehot0(rsp_valid))
      else $error("more than one afu_rsp valid");

   a_almfull_reset: assert property (@(posedge Clk_100) $fell(rst) |-> (afu_almfull == '0))
      else $error("afu_almfull high after reset");

endmodule

bind host_port_mux green_props #(.NUM_PORTS(NUM_PORTS)) u_props
(
   .Clk_100     (Clk_100),
   .rst         (rst),
   .fiu_almfull (fiu_almfull),
   .fiu_req     (fiu_req),
   .afu_rsp     (afu_rsp),
   .afu_almfull (afu_almfull)
);

/* tb_green_top.sv */
// ====================
// Testbench for green_top
// Stimulus table, FIU and memory bank models,
// scoreboard checks and a watchdog
// ====================

`timescale 1ns/10ps

module tb_green_top;

   localparam int NUM_PORTS  = 3;
   localparam int FIFO_DEPTH = 8;
   localparam int PIPE_DEPTH = 2;
   localparam int TABLE_LEN  = 12;
   localparam int TIMEOUT_NS = TABLE_LEN * 40 * 20 + 4000;

   // Read data rules of the FIU and memory models
   localparam logic [63:0] RSP_XOR = 64'h5A5A_0000_C3C3_0000;
   localparam logic [63:0] MEM_ADD = 64'h0000_0100_0000_0007;

   // One table row: host request plus a memory command
   typedef struct packed {
      logic [1:0]  port;
      logic        is_write;
      logic [31:0] addr;
      logic [63:0] data;
      logic [7:0]  tag;
      logic        mem_write;
      logic [26:0] mem_addr;
   } entry_t;

   logic                 Clk_100;
   logic                 rst;
   green_pkg::host_req_t afu_req [NUM_PORTS];
   logic [NUM_PORTS-1:0] afu_almfull;
   green_pkg::host_rsp_t afu_rsp [NUM_PORTS];
   green_pkg::fiu_req_t  fiu_req;
   logic                 fiu_almfull;
   green_pkg::fiu_rsp_t  fiu_rsp;
   green_pkg::mem_req_t  s0_req;
   logic                 s0_waitrequest;
   green_pkg::mem_rsp_t  s0_rsp;
   green_pkg::mem_req_t  m0_req;
   logic                 m0_waitrequest;
   green_pkg::mem_rsp_t  m0_rsp;

   integer              seed;
   int                  errors;
   int                  cycle;
   entry_t              stim [TABLE_LEN];
   int                  num_reads;

   // Host side scoreboard
   int                  model_cnt [NUM_PORTS];
   int                  model_ptr;
   logic                exp_fiu_valid;
   int                  exp_fiu_port;
   int                  next_idx [NUM_PORTS];
   logic                almfull_q;
   int                  fiu_seen;
   logic                issued [TABLE_LEN];
   logic                answered [TABLE_LEN];
   int                  rsp_due [TABLE_LEN];
   int                  rsp_drv_idx;
   logic                exp_rsp_valid;
   int                  exp_rsp_idx;
   int                  rsp_seen;
   int                  almfull_timer;

   // Memory side scoreboard
   int                  mem_acc;
   int                  mem_cnt;
   green_pkg::mem_req_t m0_prev;
   logic                m0_stall;
   int                  rd_list [TABLE_LEN];
   int                  rd_due [TABLE_LEN];
   int                  rd_tail;
   int                  rd_ret;
   int                  rd_drv_idx;
   logic                sh_v [PIPE_DEPTH];
   int                  sh_idx [PIPE_DEPTH];
   int                  s0_rd_seen;

   green_top
   #(
      .NUM_PORTS           (NUM_PORTS),
      .PORT_FIFO_DEPTH     (FIFO_DEPTH),
      .READDATA_PIPE_DEPTH (PIPE_DEPTH)
   )
   u_dut
   (
      .Clk_100        (Clk_100),
      .rst            (rst),
      .afu_req        (afu_req),
      .afu_almfull    (afu_almfull),
      .afu_rsp        (afu_rsp),
      .fiu_req        (fiu_req),
      .fiu_almfull    (fiu_almfull),
      .fiu_rsp        (fiu_rsp),
      .s0_req         (s0_req),
      .s0_waitrequest (s0_waitrequest),
      .s0_rsp         (s0_rsp),
      .m0_req         (m0_req),
      .m0_waitrequest (m0_waitrequest),
      .m0_rsp         (m0_rsp)
   );

   always #10 Clk_100 = ~Clk_100;

   // ====================
   // Helpers
   // ====================
   task automatic flag_error(input string msg);
      errors++;
      $display("ERROR at %0t ns: %s", $time, msg);
   endtask

   function automatic int find_next(input int p, input int from);
      int res;
      res = -1;
      for (int k = TABLE_LEN - 1; k >= from; k--)
      begin
         if (int'(stim[k].port) == p)
         begin
            res = k;
         end
      end
      return res;
   endfunction

   task automatic check_idle();
      if (fiu_req.valid || afu_almfull != '0 || s0_waitrequest)
      begin
         flag_error("host side output active around reset");
      end
      if (m0_req.read || m0_req.write || s0_rsp.readdatavalid)
      begin
         flag_error("memory side output active around reset");
      end
      for (int p = 0; p < NUM_PORTS; p++)
      begin
         if (afu_rsp[p].valid)
         begin
            flag_error($sformatf("afu_rsp[%0d] valid around reset", p));
         end
      end
   endtask

   task automatic load_table();
      stim[0]  = '{2'd0, 1'b0, 32'h0000_1000, 64'h0, 8'h11, 1'b0, 27'h000_0040};
      stim[1]  = '{2'd1, 1'b1, 32'h0000_2008, 64'hDEAD_BEEF_0000_0001, 8'h21, 1'b1, 27'h000_0041};
      stim[2]  = '{2'd2, 1'b0, 32'h0000_3010, 64'h0, 8'h31, 1'b0, 27'h012_3456};
      stim[3]  = '{2'd0, 1'b1, 32'h0000_1018, 64'h0123_4567_89AB_CDEF, 8'h12, 1'b0, 27'h000_0080};
      stim[4]  = '{2'd1, 1'b0, 32'h8000_2020, 64'h0, 8'h22, 1'b1, 27'h7FF_FFFF};
      stim[5]  = '{2'd2, 1'b1, 32'h0000_3028, 64'hFFFF_0000_FFFF_0000, 8'h32, 1'b0, 27'h000_0000};
      stim[6]  = '{2'd0, 1'b0, 32'hFFFF_FFF8, 64'h0, 8'hF3, 1'b0, 27'h400_0001};
      stim[7]  = '{2'd2, 1'b0, 32'h0000_3030, 64'h0, 8'h33, 1'b1, 27'h000_0F00};
      stim[8]  = '{2'd1, 1'b1, 32'h0000_2038, 64'h5555_AAAA_5555_AAAA, 8'h23, 1'b0, 27'h000_1234};
      stim[9]  = '{2'd0, 1'b0, 32'h0000_1040, 64'h0, 8'h14, 1'b0, 27'h2AA_AAAA};
      stim[10] = '{2'd1, 1'b0, 32'h0000_2048, 64'h0, 8'h24, 1'b1, 27'h155_5555};
      stim[11] = '{2'd2, 1'b1, 32'h0000_3050, 64'h0F0F_0F0F_F0F0_F0F0, 8'h34, 1'b0, 27'h000_00AA};
   endtask

   // ====================
   // FIU and memory bank models
   // ====================
   always @(negedge Clk_100)
   begin
      int pick;
      if (!rst)
      begin
         // Almost-full held in random windows
         if (almfull_timer == 0)
         begin
            fiu_almfull   = (($random(seed) & 3) == 0);
            almfull_timer = 1 + ($random(seed) & 7);
         end
         else
         begin
            almfull_timer--;
         end

         // Oldest due response goes out first
         pick = -1;
         for (int k = TABLE_LEN - 1; k >= 0; k--)
         begin
            if (issued[k] && !answered[k] && rsp_due[k] <= cycle)
            begin
               pick = k;
            end
         end
         fiu_rsp     = '0;
         rsp_drv_idx = pick;
         if (pick >= 0)
         begin
            answered[pick]   = 1'b1;
            fiu_rsp.valid    = 1'b1;
            fiu_rsp.is_write = stim[pick].is_write;
            fiu_rsp.data     = stim[pick].is_write ? 64'h0 : {32'h0, stim[pick].addr} ^ RSP_XOR;
            fiu_rsp.tag      = {stim[pick].port, stim[pick].tag};
         end

         m0_waitrequest = (($random(seed) & 3) == 0);
         m0_rsp         = '0;
         rd_drv_idx     = -1;
         if (rd_ret < rd_tail && rd_due[rd_ret] <= cycle)
         begin
            m0_rsp.readdatavalid = 1'b1;
            m0_rsp.readdata      = 64'(stim[rd_list[rd_ret]].mem_addr) + MEM_ADD;
            rd_drv_idx           = rd_list[rd_ret];
            rd_ret++;
         end
      end
   end

   // ====================
   // Monitors and checks
   // ====================
   always @(posedge Clk_100)
   begin
      int             g;
      int             idx;
      int             k2;
      logic [1:0]     fport;
      logic           ev;
      logic           exp_lvl;
      logic [63:0]    exp_data;
      cycle++;
      if (!rst)
      begin
         if (almfull_q && fiu_req.valid)
         begin
            flag_error("fiu_req valid in the cycle after fiu_almfull");
         end

         // Issue order against the round-robin model
         if (fiu_req.valid !== exp_fiu_valid)
         begin
            flag_error($sformatf("fiu_req valid %b, expected %b", fiu_req.valid, exp_fiu_valid));
         end
         else if (fiu_req.valid)
         begin
            fport = fiu_req.tag[9:8];
            idx   = next_idx[fport];
            if (int'(fport) != exp_fiu_port)
            begin
               flag_error($sformatf("fiu_req port %0d, expected %0d", fport, exp_fiu_port));
            end
            else if (idx < 0)
            begin
               flag_error($sformatf("unexpected request from port %0d", fport));
            end
            else
            begin
               if (fiu_req.is_write != stim[idx].is_write || fiu_req.addr != stim[idx].addr
                   || fiu_req.tag[7:0] != stim[idx].tag || fiu_req.data != stim[idx].data)
               begin
                  flag_error($sformatf("fiu_req fields wrong for row %0d", idx));
               end
               issued[idx]     = 1'b1;
               rsp_due[idx]    = cycle + 1 + ($random(seed) & 7);
               next_idx[fport] = find_next(fport, idx + 1);
               fiu_seen++;
            end
         end

         // Almost-full levels follow the modelled FIFO fill
         for (int p = 0; p < NUM_PORTS; p++)
         begin
            exp_lvl = (model_cnt[p] >= FIFO_DEPTH - 2);
            if (afu_almfull[p] !== exp_lvl)
            begin
               flag_error($sformatf("afu_almfull[%0d] %b, expected %b",
                                    p, afu_almfull[p], exp_lvl));
            end
         end

         exp_fiu_valid = 1'b0;
         if (!fiu_almfull)
         begin
            g = -1;
            for (int k = 0; k < NUM_PORTS; k++)
            begin
               k2 = (model_ptr + k) % NUM_PORTS;
               if (g < 0 && model_cnt[k2] > 0)
               begin
                  g = k2;
               end
            end
            if (g >= 0)
            begin
               exp_fiu_valid = 1'b1;
               exp_fiu_port  = g;
               model_cnt[g]--;
               model_ptr     = (g + 1) % NUM_PORTS;
            end
         end
         for (int p = 0; p < NUM_PORTS; p++)
         begin
            if (afu_req[p].valid)
            begin
               model_cnt[p]++;
            end
         end
         almfull_q = fiu_almfull;

         // Response steering, one cycle after fiu_rsp
         for (int p = 0; p < NUM_PORTS; p++)
         begin
            ev = exp_rsp_valid && (int'(stim[exp_rsp_idx].port) == p);
            if (afu_rsp[p].valid !== ev)
            begin
               flag_error($sformatf("afu_rsp[%0d] valid %b, expected %b", p, afu_rsp[p].valid, ev));
            end
            else if (ev)
            begin
               exp_data = {32'h0, stim[exp_rsp_idx].addr} ^ RSP_XOR;
               if (afu_rsp[p].is_write != stim[exp_rsp_idx].is_write
                   || afu_rsp[p].tag != stim[exp_rsp_idx].tag
                   || (!stim[exp_rsp_idx].is_write && afu_rsp[p].data != exp_data))
               begin
                  flag_error($sformatf("afu_rsp[%0d] wrong for row %0d", p, exp_rsp_idx));
               end
               rsp_seen++;
            end
         end
         exp_rsp_valid = fiu_rsp.valid;
         exp_rsp_idx   = rsp_drv_idx;

         // Waitrequest level from the modelled command FIFO fill
         exp_lvl = (mem_cnt >= FIFO_DEPTH - 1);
         if (s0_waitrequest !== exp_lvl)
         begin
            flag_error($sformatf("s0_waitrequest %b, expected %b", s0_waitrequest, exp_lvl));
         end
         if ((s0_req.read || s0_req.write) && !s0_waitrequest)
         begin
            mem_cnt++;
         end

         // Memory commands in order, held under waitrequest
         if (m0_stall && m0_req !== m0_prev)
         begin
            flag_error("m0_req changed while m0_waitrequest was high");
         end
         if ((m0_req.read || m0_req.write) && !m0_waitrequest)
         begin
            mem_cnt--;
            if (mem_acc >= TABLE_LEN)
            begin
               flag_error("extra command on m0_req");
            end
            else
            begin
               if (m0_req.write != stim[mem_acc].mem_write || m0_req.read == stim[mem_acc].mem_write
                   || m0_req.address != stim[mem_acc].mem_addr || m0_req.byteenable != 8'hFF
                   || m0_req.burstcount != 7'd1
                   || (m0_req.write && m0_req.writedata != stim[mem_acc].data))
               begin
                  flag_error($sformatf("m0_req wrong for row %0d", mem_acc));
               end
               if (!stim[mem_acc].mem_write)
               begin
                  rd_list[rd_tail] = mem_acc;
                  rd_due[rd_tail]  = cycle + 1 + ($random(seed) & 3);
                  if (rd_tail > 0 && rd_due[rd_tail] <= rd_due[rd_tail-1])
                  begin
                     rd_due[rd_tail] = rd_due[rd_tail-1] + 1;
                  end
                  rd_tail++;
               end
               mem_acc++;
            end
         end
         m0_stall = (m0_req.read || m0_req.write) && m0_waitrequest;
         m0_prev  = m0_req;

         // Read data delayed by the pipe depth
         if (s0_rsp.readdatavalid !== sh_v[PIPE_DEPTH-1])
         begin
            flag_error($sformatf("s0_rsp readdatavalid %b, expected %b",
                                 s0_rsp.readdatavalid, sh_v[PIPE_DEPTH-1]));
         end
         else if (sh_v[PIPE_DEPTH-1])
         begin
            exp_data = 64'(stim[sh_idx[PIPE_DEPTH-1]].mem_addr) + MEM_ADD;
            if (s0_rsp.readdata != exp_data)
            begin
               flag_error($sformatf("s0_rsp readdata %h, expected %h", s0_rsp.readdata, exp_data));
            end
            s0_rd_seen++;
         end
         for (int i = PIPE_DEPTH - 1; i > 0; i--)
         begin
            sh_v[i]   = sh_v[i-1];
            sh_idx[i] = sh_idx[i-1];
         end
         sh_v[0]   = m0_rsp.readdatavalid;
         sh_idx[0] = rd_drv_idx;
      end
   end

   // ====================
   // Main sequence
   // ====================
   initial
   begin
      entry_t e;
      seed          = 32'h8643_6345;
      errors        = 0;
      cycle         = 0;
      Clk_100       = 1'b0;
      rst           = 1'b1;
      fiu_almfull   = 1'b0;
      fiu_rsp       = '0;
      s0_req        = '0;
      m0_waitrequest = 1'b0;
      m0_rsp        = '0;
      model_ptr     = 0;
      exp_fiu_valid = 1'b0;
      exp_fiu_port  = 0;
      almfull_q     = 1'b0;
      fiu_seen      = 0;
      rsp_drv_idx   = -1;
      exp_rsp_valid = 1'b0;
      exp_rsp_idx   = 0;
      rsp_seen      = 0;
      almfull_timer = 0;
      mem_acc       = 0;
      mem_cnt       = 0;
      m0_prev       = '0;
      m0_stall      = 1'b0;
      rd_tail       = 0;
      rd_ret        = 0;
      rd_drv_idx    = -1;
      s0_rd_seen    = 0;
      num_reads     = 0;
      load_table();
      for (int p = 0; p < NUM_PORTS; p++)
      begin
         afu_req[p]   = '0;
         model_cnt[p] = 0;
         next_idx[p]  = find_next(p, 0);
      end
      for (int k = 0; k < TABLE_LEN; k++)
      begin
         issued[k]   = 1'b0;
         answered[k] = 1'b0;
         rsp_due[k]  = 0;
         if (!stim[k].mem_write)
         begin
            num_reads++;
         end
      end
      for (int i = 0; i < PIPE_DEPTH; i++)
      begin
         sh_v[i]   = 1'b0;
         sh_idx[i] = 0;
      end

      // Five reset cycles, outputs checked once the first edge has passed
      for (int i = 0; i < 5; i++)
      begin
         @(negedge Clk_100);
         if (i > 0)
         begin
            check_idle();
         end
      end
      rst <= 1'b0;
      @(negedge Clk_100);
      check_idle();

      for (int i = 0; i < TABLE_LEN; i++)
      begin
         @(negedge Clk_100);
         e = stim[i];
         for (int p = 0; p < NUM_PORTS; p++)
         begin
            afu_req[p] = '0;
         end
         s0_req = '0;
         while (afu_almfull[e.port] || s0_waitrequest)
         begin
            @(negedge Clk_100);
         end
         afu_req[e.port] = '{1'b1, e.is_write, e.addr, e.data, e.tag};
         s0_req.read       = !e.mem_write;
         s0_req.write      = e.mem_write;
         s0_req.address    = e.mem_addr;
         s0_req.writedata  = e.data;
         s0_req.byteenable = 8'hFF;
         s0_req.burstcount = 7'd1;
      end
      @(negedge Clk_100);
      for (int p = 0; p < NUM_PORTS; p++)
      begin
         afu_req[p] = '0;
      end
      s0_req = '0;

      // Everything queued has to drain
      wait (fiu_seen == TABLE_LEN && rsp_seen == TABLE_LEN
            && mem_acc == TABLE_LEN && s0_rd_seen == num_reads);
      repeat (5) @(negedge Clk_100);

      $display("Closing: %0d errors, %0d requests, %0d responses, %0d commands, %0d reads",
               errors, fiu_seen, rsp_seen, mem_acc, s0_rd_seen);
      if (errors == 0)
      begin
         $display("Everything OK");
      end
      else
      begin
         $display("Something failed");
      end
      $finish;
   end

   // Watchdog scaled to the table length
   initial
   begin
      #(TIMEOUT_NS);
      $display("Timeout: the run did not finish within %0d ns, %0d errors so far",
               TIMEOUT_NS, errors);
      $display("Something failed");
      $finish;
   end

endmodule

/* sim.f */
green_pkg.sv
port_fifo.sv
rr_arbiter.sv
host_port_mux.sv
local_mem_bridge.sv
green_top.sv
green_props.sv
tb_green_top.sv
